// File: bench/tb_box_filter_top.sv
`timescale 1ns/1ps

module tb_box_filter_top;

  localparam int n_cases   = 6;
  localparam int max_side  = 32;
  localparam int pat_const = 0;
  localparam int pat_ramp  = 1;
  localparam int pat_rand  = 2;

  // one frame per entry, all frames run back to back
  localparam int case_side [n_cases] = '{13, 20, 31, 16, 14, 25};
  localparam int case_pat  [n_cases] = '{pat_const, pat_ramp, pat_rand, pat_ramp, pat_rand,
                                         pat_const};
  localparam int case_gaps [n_cases] = '{0, 0, 1, 1, 0, 0};
  localparam int case_val  [n_cases] = '{200, 0, 0, 0, 0, 255};

  logic                      clk = 1'b0;
  logic                      rst_n;
  logic [win_pkg::pix_w-1:0] pix_i;
  logic                      pix_valid_i;
  logic                      frame_start_i;
  logic [win_pkg::img_w-1:0] img_size_i;
  logic [win_pkg::sum_w-1:0] sum_o;
  logic                      sum_valid_o;
  logic                      frame_done_o;

  int unsigned rand_state = 31372;
  int          cyc;
  int          max_cycles;
  int          err_value;
  int          err_count;
  int          err_timing;
  int          done_cnt;
  logic [7:0]  frame_mem [max_side][max_side];
  int          exp_sum [$];
  bit          exp_last [$];  // marks the final window of each frame
  int          exp_accept [$];  // edge that accepted the pixel closing each window

  box_filter_top i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .pix_i         (pix_i),
    .pix_valid_i   (pix_valid_i),
    .frame_start_i (frame_start_i),
    .img_size_i    (img_size_i),
    .sum_o         (sum_o),
    .sum_valid_o   (sum_valid_o),
    .frame_done_o  (frame_done_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc = cyc + 1;
    if (cyc >= max_cycles) begin
      $display("timeout: no end of the run after %0d cycles", cyc);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int unsigned next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 16;
  endfunction

  task automatic fill_frame(input int idx);
    for (int r = 0; r < case_side[idx]; r++) begin
      for (int c = 0; c < case_side[idx]; c++) begin
        if (case_pat[idx] == pat_const) begin
          frame_mem[r][c] = case_val[idx][7:0];
        end else if (case_pat[idx] == pat_ramp) begin
          frame_mem[r][c] = 8'((r * 7 + c * 3) % 256);
        end else begin
          frame_mem[r][c] = 8'(next_rand() % 256);
        end
      end
    end
  endtask

  // every position where the 13x13 window lies inside the image, in raster order
  task automatic build_expected(input int side);
    int acc;
    for (int r = win_pkg::win_size - 1; r < side; r++) begin
      for (int c = win_pkg::win_size - 1; c < side; c++) begin
        acc = 0;
        for (int i = r - (win_pkg::win_size - 1); i <= r; i++) begin
          for (int j = c - (win_pkg::win_size - 1); j <= c; j++) begin
            acc = acc + frame_mem[i][j];
          end
        end
        exp_sum.push_back(acc);
        exp_last.push_back((r == side - 1) && (c == side - 1));
      end
    end
  endtask

  task automatic drive_cycle(input bit fs, input bit valid, input int pix, input int size);
    @(negedge clk);
    frame_start_i = fs;
    pix_valid_i   = valid;
    pix_i         = pix[win_pkg::pix_w-1:0];
    img_size_i    = size[win_pkg::img_w-1:0];
  endtask

  task automatic send_frame(input int idx);
    int side;
    int gap;
    side = case_side[idx];
    // the old side is kept during the frame start so the previous frame ends on it
    drive_cycle(1'b1, 1'b0, 0, int'(img_size_i));
    for (int r = 0; r < side; r++) begin
      for (int c = 0; c < side; c++) begin
        if (case_gaps[idx] != 0 && next_rand() % 4 == 0) begin
          gap = 1 + next_rand() % 3;
          repeat (gap) drive_cycle(1'b0, 1'b0, 0, side);
        end
        drive_cycle(1'b0, 1'b1, int'(frame_mem[r][c]), side);
        if (r >= win_pkg::win_size - 1 && c >= win_pkg::win_size - 1) begin
          exp_accept.push_back(cyc + 1);  // taken at the coming rising edge
        end
      end
    end
  endtask

  task automatic check_sum();
    int exp_val;
    int acc_cyc;
    if (exp_sum.size() == 0) begin
      $display("extra sum %0d at %0t ns while no window is expected", sum_o, $time);
      err_count++;
    end else begin
      exp_val = exp_sum.pop_front();
      void'(exp_last.pop_front());
      if (sum_o !== exp_val[win_pkg::sum_w-1:0]) begin
        $display("Fail %0t ns: sum %0d, expected %0d", $time, sum_o, exp_val);
        err_value++;
      end
      if (exp_accept.size() == 0) begin
        $display("sum at %0t ns has no accepted pixel that closes its window", $time);
        err_count++;
      end else begin
        acc_cyc = exp_accept.pop_front();
        // the consumer takes the sum at the next rising edge
        if (cyc + 1 - acc_cyc != 4) begin
          $display("Fail %0t ns: sum latency %0d cycles, expected 4", $time,
                   cyc + 1 - acc_cyc);
          err_timing++;
        end
      end
    end
  endtask

  task automatic check_done();
    done_cnt++;
    if (exp_last.size() == 0 || exp_last[0] == 1'b0) begin
      $display("Fail %0t ns: frame_done_o pulsed before the last window of a frame", $time);
      err_timing++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      if (sum_valid_o) check_sum();  // must run before the frame end check
      if (frame_done_o) check_done();
    end
  end

  initial begin
    int total;
    rst_n         = 1'b0;
    pix_i         = '0;
    pix_valid_i   = 1'b0;
    frame_start_i = 1'b0;
    img_size_i    = case_side[0][win_pkg::img_w-1:0];
    cyc           = 0;
    err_value     = 0;
    err_count     = 0;
    err_timing    = 0;
    done_cnt      = 0;
    total         = 0;
    for (int i = 0; i < n_cases; i++) begin
      total = total + case_side[i] * case_side[i];
    end
    max_cycles = 2 * total + 1000;

    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    if (sum_valid_o !== 1'b0 || frame_done_o !== 1'b0) begin
      $display("Fail %0t ns: sum_valid_o or frame_done_o high after reset", $time);
      err_timing++;
    end

    for (int idx = 0; idx < n_cases; idx++) begin
      fill_frame(idx);
      build_expected(case_side[idx]);
      send_frame(idx);
    end
    drive_cycle(1'b0, 1'b0, 0, int'(img_size_i));

    while (exp_sum.size() != 0 || done_cnt < n_cases) @(negedge clk);
    repeat (20) @(negedge clk);  // room for any extra output
    if (done_cnt != n_cases) begin
      $display("frame_done_o pulsed %0d times for %0d frames", done_cnt, n_cases);
      err_count++;
    end

    $display("errors: %0d value, %0d count, %0d timing", err_value, err_count, err_timing);
    if (err_value + err_count + err_timing == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: box_filter_top.f
rtl/win_pkg.sv
rtl/line_buffer_bank.sv
rtl/window_datapath.sv
rtl/window_ctrl.sv
rtl/window_sum.sv
rtl/box_filter_top.sv
bench/tb_box_filter_top.sv

// File: rtl/box_filter_top.sv
`timescale 1ns/1ps

module box_filter_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [win_pkg::pix_w-1:0] pix_i,
  input  logic                      pix_valid_i,
  input  logic                      frame_start_i,
  input  logic [win_pkg::img_w-1:0] img_size_i,
  output logic [win_pkg::sum_w-1:0] sum_o,
  output logic                      sum_valid_o,
  output logic                      frame_done_o
);

  logic [win_pkg::win_size*win_pkg::pix_w-1:0]                  col;
  logic                                                         col_valid;
  logic [win_pkg::win_size*win_pkg::win_size*win_pkg::pix_w-1:0] window;
  logic                                                         col_ge_thr;
  logic                                                         col_eq_max;
  logic                                                         row_eq_max;
  logic                                                         count_en;
  logic                                                         reset_en;
  logic                                                         win_valid;

  line_buffer_bank i_line_buffer_bank (
    .clk         (clk),
    .rst_n       (rst_n),
    .pix_i       (pix_i),
    .pix_valid_i (pix_valid_i),
    .img_size_i  (img_size_i),
    .reset_en_i  (reset_en),
    .col_o       (col),
    .col_valid_o (col_valid)
  );

  window_datapath i_window_datapath (
    .clk          (clk),
    .rst_n        (rst_n),
    .col_i        (col),
    .data_valid_i (col_valid),
    .count_en_i   (count_en),
    .reset_en_i   (reset_en),
    .img_size_i   (img_size_i),
    .window_o     (window),
    .col_ge_thr_o (col_ge_thr),
    .col_eq_max_o (col_eq_max),
    .row_eq_max_o (row_eq_max)
  );

  window_ctrl i_window_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_start_i (frame_start_i),
    .col_valid_i   (col_valid),
    .col_ge_thr_i  (col_ge_thr),
    .col_eq_max_i  (col_eq_max),
    .row_eq_max_i  (row_eq_max),
    .count_en_o    (count_en),
    .reset_en_o    (reset_en),
    .win_valid_o   (win_valid),
    .frame_done_o  (frame_done_o)
  );

  window_sum i_window_sum (
    .clk         (clk),
    .rst_n       (rst_n),
    .window_i    (window),
    .win_valid_i (win_valid),
    .sum_o       (sum_o),
    .sum_valid_o (sum_valid_o)
  );

endmodule

// File: rtl/line_buffer_bank.sv
`timescale 1ns/1ps

module line_buffer_bank (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  logic [win_pkg::pix_w-1:0]                   pix_i,
  input  logic                                        pix_valid_i,
  input  logic [win_pkg::img_w-1:0]                   img_size_i,
  input  logic                                        reset_en_i,
  output logic [win_pkg::win_size*win_pkg::pix_w-1:0] col_o,
  output logic                                        col_valid_o
);

  logic [win_pkg::img_w-1:0]                          ptr_q;
  logic [win_pkg::img_w-1:0]                          wr_addr;
  logic [win_pkg::img_w-1:0]                          addr_nxt;
  logic [(win_pkg::win_size-1)*win_pkg::pix_w-1:0]    rd_col;
  logic [(win_pkg::win_size-1)*win_pkg::pix_w-1:0]    wr_col;

  // a pixel in the cycle of the frame clear still lands in column 0
  assign wr_addr  = reset_en_i ? '0 : ptr_q;
  assign addr_nxt = wr_addr + 1'b1;

  // every row moves down by one, the new pixel becomes row 11
  assign wr_col = {pix_i, rd_col[(win_pkg::win_size-1)*win_pkg::pix_w-1:win_pkg::pix_w]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (pix_valid_i) begin
      ptr_q <= (addr_nxt == img_size_i) ? '0 : addr_nxt;  // wraps after the last column
    end else if (reset_en_i) begin
      ptr_q <= '0;
    end
  end

  for (genvar k = 0; k < win_pkg::win_size - 1; k++) begin : g_row
    logic [win_pkg::pix_w-1:0] mem [2**win_pkg::img_w];  // row k holds the line 12-k rows back

    assign rd_col[k*win_pkg::pix_w +: win_pkg::pix_w] = mem[wr_addr];

    always_ff @(posedge clk) begin
      if (pix_valid_i) begin
        mem[wr_addr] <= wr_col[k*win_pkg::pix_w +: win_pkg::pix_w];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_o <= 1'b0;
    end else begin
      col_valid_o <= pix_valid_i;
    end
  end

  // oldest row sits at the bottom of the column, the new pixel on top
  always_ff @(posedge clk) begin
    if (pix_valid_i) begin
      col_o <= {pix_i, rd_col};
    end
  end

endmodule

// File: rtl/win_pkg.sv
package win_pkg;

  // window geometry
  localparam int unsigned win_size = 13;   // pixels per window side

  // pixel and image size
  localparam int unsigned pix_w = 8;       // greyscale pixel width
  localparam int unsigned img_w = 9;       // image side runs from 13 to 511

  // position counters are one bit wider than the image side
  localparam int unsigned cnt_w = 10;

  // adder widths
  localparam int unsigned row_sum_w = 12;  // 13 pixels of 255 fit in 12 bits
  localparam int unsigned sum_w = 16;      // 169 pixels of 255 fit in 16 bits

endpackage

// File: rtl/window_ctrl.sv
`timescale 1ns/1ps

module window_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic frame_start_i,
  input  logic col_valid_i,
  input  logic col_ge_thr_i,
  input  logic col_eq_max_i,
  input  logic row_eq_max_i,
  output logic count_en_o,
  output logic reset_en_o,
  output logic win_valid_o,
  output logic frame_done_o
);

  logic                                  fill_q;  // rows 0 to 11 are loading the line memories
  logic                                  run_q;   // rows from 12 on produce windows
  logic [$clog2(win_pkg::win_size)-1:0]  fill_row_q;
  logic                                  row_end;
  logic                                  fill_end;
  logic                                  frame_end;

  assign count_en_o = col_valid_i & (fill_q | run_q);
  assign row_end    = count_en_o & col_eq_max_i;
  assign fill_end   = row_end & fill_q & (fill_row_q == (win_pkg::win_size - 2));
  assign frame_end  = row_end & run_q & row_eq_max_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reset_en_o <= 1'b0;
    end else begin
      reset_en_o <= frame_start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fill_q     <= 1'b0;
      run_q      <= 1'b0;
      fill_row_q <= '0;
    end else if (reset_en_o) begin
      fill_q     <= 1'b1;
      run_q      <= 1'b0;
      fill_row_q <= '0;
    end else begin
      if (fill_end) begin
        fill_q <= 1'b0;
        run_q  <= 1'b1;
      end else if (frame_end) begin
        run_q <= 1'b0;
      end
      if (row_end && fill_q) begin
        fill_row_q <= fill_row_q + 1'b1;
      end
    end
  end

  // the last window is the only one flagged after the FSM has gone idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o  <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      win_valid_o  <= run_q & col_valid_i & col_ge_thr_i;
      frame_done_o <= win_valid_o & ~fill_q & ~run_q;
    end
  end

endmodule

// File: rtl/window_datapath.sv
`timescale 1ns/1ps

module window_datapath (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  input  logic [win_pkg::win_size*win_pkg::pix_w-1:0]                  col_i,
  input  logic                                                         data_valid_i,
  input  logic                                                         count_en_i,
  input  logic                                                         reset_en_i,
  input  logic [win_pkg::img_w-1:0]                                    img_size_i,
  output logic [win_pkg::win_size*win_pkg::win_size*win_pkg::pix_w-1:0] window_o,
  output logic                                                         col_ge_thr_o,
  output logic                                                         col_eq_max_o,
  output logic                                                         row_eq_max_o
);

  logic [win_pkg::win_size*win_pkg::pix_w-1:0]                        col_q;
  logic [(win_pkg::win_size-1)*win_pkg::win_size*win_pkg::pix_w-1:0]  hist_q;
  logic [win_pkg::cnt_w-1:0]                                          col_cnt_q;
  logic [win_pkg::cnt_w-1:0]                                          row_cnt_q;
  logic [win_pkg::cnt_w-1:0]                                          col_nxt;
  logic [win_pkg::cnt_w-1:0]                                          row_nxt;
  logic [win_pkg::cnt_w-1:0]                                          side_ext;

  // the latched column is the newest window column, older ones shift towards column 0
  always_ff @(posedge clk) begin
    if (data_valid_i) begin
      col_q  <= col_i;
      hist_q <= {col_q,
                 hist_q[(win_pkg::win_size-1)*win_pkg::win_size*win_pkg::pix_w-1:
                        win_pkg::win_size*win_pkg::pix_w]};
    end
  end

  assign window_o = {col_q, hist_q};

  assign side_ext = {{(win_pkg::cnt_w - win_pkg::img_w){1'b0}}, img_size_i};
  assign col_nxt  = col_cnt_q + 1'b1;
  assign row_nxt  = row_cnt_q + 1'b1;

  assign col_eq_max_o = (col_nxt == side_ext);  // current column is img_size_i - 1
  assign row_eq_max_o = (row_nxt == side_ext);
  assign col_ge_thr_o = (col_cnt_q >= (win_pkg::win_size - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt_q <= '0;
    end else if (reset_en_i) begin
      col_cnt_q <= '0;
    end else if (count_en_i) begin
      if (col_eq_max_o) begin
        col_cnt_q <= '0;
      end else begin
        col_cnt_q <= col_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt_q <= '0;
    end else if (reset_en_i) begin
      row_cnt_q <= '0;
    end else if (count_en_i && col_eq_max_o) begin
      if (row_eq_max_o) begin
        row_cnt_q <= '0;  // frame complete, wait for the next clear
      end else begin
        row_cnt_q <= row_nxt;
      end
    end
  end

endmodule

// File: rtl/window_sum.sv
`timescale 1ns/1ps

module window_sum (
  input  logic                                                         clk,
  input  logic                                                         rst_n,
  input  logic [win_pkg::win_size*win_pkg::win_size*win_pkg::pix_w-1:0] window_i,
  input  logic                                                         win_valid_i,
  output logic [win_pkg::sum_w-1:0]                                    sum_o,
  output logic                                                         sum_valid_o
);

  logic [win_pkg::row_sum_w-1:0] col_sum   [win_pkg::win_size];
  logic [win_pkg::row_sum_w-1:0] col_sum_q [win_pkg::win_size];
  logic [win_pkg::sum_w-1:0]     total;
  logic                          valid_q;

  always_comb begin
    for (int j = 0; j < win_pkg::win_size; j++) begin
      col_sum[j] = '0;
      for (int i = 0; i < win_pkg::win_size; i++) begin
        col_sum[j] = col_sum[j] + {{(win_pkg::row_sum_w - win_pkg::pix_w){1'b0}},
            window_i[(j*win_pkg::win_size + i)*win_pkg::pix_w +: win_pkg::pix_w]};
      end
    end
  end

  always_comb begin
    total = '0;
    for (int j = 0; j < win_pkg::win_size; j++) begin
      total = total + {{(win_pkg::sum_w - win_pkg::row_sum_w){1'b0}}, col_sum_q[j]};
    end
  end

  // each stage carries its own valid so windows may follow back to back
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      sum_valid_o <= 1'b0;
    end else begin
      valid_q     <= win_valid_i;
      sum_valid_o <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (win_valid_i) begin
      col_sum_q <= col_sum;
    end
    if (valid_q) begin
      sum_o <= total;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_box_filter_top \
  -f box_filter_top.f -o sim_box_filter

out=$(./obj_dir/sim_box_filter)
echo "$out"

if echo "$out" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
